/* rtl/dma_wr_params.svh */
/*
 * Widths and depths of the ring write engine.
 * Words are fixed at 32 bits. Counts in words fit DMA_SIZE_W bits.
 */
`ifndef DMA_WR_PARAMS_SVH
`define DMA_WR_PARAMS_SVH

// datapath
`define DMA_DATA_W              32
`define DMA_BYTES_LOG2          2
`define DMA_ADDR_W              32

// counts in words and cycles
`define DMA_SIZE_W              24
`define DMA_LEN_W               8
`define DMA_TIMER_W             8

// no burst may cross this boundary
`define DMA_ALIGN_LOG2          12

// fifo depths as log2
`define DMA_DFIFO_DEPTH_LOG2    9
`define DMA_CFIFO_DEPTH_LOG2    4

`endif

/* rtl/dma_wr_pkg.sv */
/*
 * Shared types of the ring write engine and its fixed AW fields.
 */
`include "dma_wr_params.svh"

package dma_wr_pkg;

    typedef logic [`DMA_DATA_W-1:0]     data_t;
    typedef logic [`DMA_ADDR_W-1:0]     addr_t;
    typedef logic [`DMA_SIZE_W-1:0]     words_t;
    typedef logic [`DMA_LEN_W-1:0]      len_t;
    typedef logic [`DMA_DATA_W/8-1:0]   strb_t;
    typedef logic [`DMA_TIMER_W-1:0]    timer_t;

    typedef enum logic [1:0] {
        IDLE,
        GATHER,
        ISSUE
    } plan_state_t;

    // incrementing bursts of full words
    localparam logic [2:0] AW_SIZE  = 3'(`DMA_BYTES_LOG2);
    localparam logic [1:0] AW_BURST = 2'b01;
    localparam logic [3:0] AW_CACHE = 4'b0001;

endpackage

/* rtl/word_fifo.sv */
/*
 * First-word-fall-through FIFO with a combinational read of its array.
 * o_ready stays low during reset and for one cycle after it.
 */
`timescale 1ns/10ps

module word_fifo #(
    parameter int WIDTH      = 8,
    parameter int DEPTH_LOG2 = 4
) (
    input  logic             aclk,
    input  logic             aresetn,
    input  logic [WIDTH-1:0] i_data,
    input  logic             i_valid,
    output logic             o_ready,
    output logic [WIDTH-1:0] o_data,
    output logic             o_valid,
    input  logic             i_ready,
    output logic             o_push
);

    logic [WIDTH-1:0]    mem [1 << DEPTH_LOG2];
    logic [DEPTH_LOG2:0] wr_ptr;
    logic [DEPTH_LOG2:0] rd_ptr;
    logic [DEPTH_LOG2:0] wr_ptr_nx;
    logic [DEPTH_LOG2:0] rd_ptr_nx;
    logic                wr_en;
    logic                rd_en;
    logic                not_full;
    logic                not_empty;

    assign wr_en     = i_valid & not_full;
    assign rd_en     = not_empty & i_ready;
    assign wr_ptr_nx = wr_ptr + {{DEPTH_LOG2{1'b0}}, wr_en};
    assign rd_ptr_nx = rd_ptr + {{DEPTH_LOG2{1'b0}}, rd_en};

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            not_full  <= 1'b0;
            not_empty <= 1'b0;
        end else begin
            wr_ptr    <= wr_ptr_nx;
            rd_ptr    <= rd_ptr_nx;
            // full when the pointers differ only in the wrap bit
            not_full  <= (wr_ptr_nx ^ rd_ptr_nx) != {1'b1, {DEPTH_LOG2{1'b0}}};
            not_empty <= wr_ptr_nx != rd_ptr_nx;
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[wr_ptr[DEPTH_LOG2-1:0]] <= i_data;
        end
    end

    assign o_ready = not_full;
    assign o_data  = mem[rd_ptr[DEPTH_LOG2-1:0]];
    assign o_valid = not_empty;
    assign o_push  = wr_en;

endmodule

/* rtl/burst_planner.sv */
/*
 * Gathers pushed words into bursts of at most awlen+1 words, never more
 * than the free ring capacity. A short burst leaves after the timeout.
 * i_update is ignored while o_busy is high.
 */
`timescale 1ns/10ps

module burst_planner
    import dma_wr_pkg::*;
(
    input  logic   aclk,
    input  logic   aresetn,
    input  logic   i_enable,
    output logic   o_busy,
    input  logic   i_update,
    output logic   o_update_apply,
    input  words_t i_ring_size,
    input  len_t   i_awlen,
    input  timer_t i_timeout,
    input  logic   i_word_push,
    input  len_t   i_permit_len,
    input  logic   i_permit_valid,
    input  logic   i_outstanding,
    output words_t o_plan_len,
    output logic   o_plan_valid,
    input  logic   i_plan_ready
);

    plan_state_t state;
    words_t      pending;
    words_t      free_cap;
    words_t      avail;
    words_t      max_len;
    words_t      issue_len;
    words_t      permit_add;
    timer_t      timer;
    timer_t      timeout_q;
    logic        apply;
    logic        issue;
    logic        drained;

    assign apply        = i_update & ~o_busy;
    assign o_plan_valid = (state == ISSUE);
    assign issue        = o_plan_valid & i_plan_ready;
    assign issue_len    = issue ? o_plan_len : '0;
    assign permit_add   = i_permit_valid ? words_t'(i_permit_len) + 1'b1 : '0;
    assign avail        = (pending < free_cap) ? pending : free_cap;
    assign max_len      = words_t'(i_awlen) + 1'b1;

    // nothing left here or further down the pipe
    assign drained = (state == IDLE) && (pending == '0) && i_plan_ready && !i_outstanding;

    // ------------------------------------------------------------------------
    // word and capacity accounting
    // ------------------------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            pending  <= '0;
            free_cap <= '0;
        end else begin
            pending <= pending + words_t'(i_word_push) - issue_len;
            if (apply) begin
                free_cap <= i_ring_size;
            end else begin
                free_cap <= free_cap + permit_add - issue_len;
            end
        end
    end

    // ------------------------------------------------------------------------
    // burst fsm
    // ------------------------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= IDLE;
            timer <= '0;
        end else begin
            case (state)
                IDLE: begin
                    timer <= '0;
                    if (o_busy && pending != '0) begin
                        state <= GATHER;
                    end
                end
                GATHER: begin
                    if (avail >= max_len) begin
                        state <= ISSUE;
                    end else if (avail != '0 && timer >= timeout_q) begin
                        state <= ISSUE;
                    end else if (timer != '1) begin
                        timer <= timer + 1'b1;
                    end
                end
                ISSUE: begin
                    if (i_plan_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // length is frozen once ISSUE is entered
    always_ff @(posedge aclk) begin
        if (state == GATHER) begin
            o_plan_len <= (avail >= max_len) ? max_len : avail;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            o_busy         <= 1'b0;
            o_update_apply <= 1'b0;
            timeout_q      <= '0;
        end else begin
            o_update_apply <= apply;
            if (apply) begin
                timeout_q <= i_timeout;
            end
            if (!o_busy) begin
                o_busy <= i_enable;
            end else if (!i_enable && drained) begin
                o_busy <= 1'b0;
            end
        end
    end

endmodule

/* rtl/burst_addr_gen.sv */
/*
 * Places planned bursts on the ring at base + 4 * index and issues them on AW.
 * Pieces split at the ring end and at 4 KiB pages. The base must be word
 * aligned and the ring size nonzero. Both are taken on i_update_apply.
 */
`timescale 1ns/10ps
`include "dma_wr_params.svh"

module burst_addr_gen
    import dma_wr_pkg::*;
(
    input  logic   aclk,
    input  logic   aresetn,
    input  logic   i_update_apply,
    input  words_t i_ring_size,
    input  addr_t  i_base_addr,
    input  words_t i_plan_len,
    input  logic   i_plan_valid,
    output logic   o_plan_ready,
    output addr_t  o_awaddr,
    output len_t   o_awlen,
    output logic   o_awvalid,
    input  logic   i_awready,
    output len_t   o_cmd_len,
    output logic   o_cmd_push,
    input  logic   i_wcmd_ready,
    input  logic   i_bcmd_ready
);

    localparam int PAGE_W = `DMA_ALIGN_LOG2 - `DMA_BYTES_LOG2;

    words_t          ring_size_q;
    addr_t           base_q;
    words_t          index;
    words_t          index_nx;
    words_t          remain;
    words_t          to_end;
    words_t          to_page;
    words_t          piece;
    logic [PAGE_W:0] page_left;
    logic            aw_fire;

    assign o_plan_ready = (remain == '0);
    assign o_awaddr     = base_q + (addr_t'(index) << `DMA_BYTES_LOG2);

    // words left before the ring end and before the next page
    assign to_end    = ring_size_q - index;
    assign page_left = {1'b1, {PAGE_W{1'b0}}}
                     - {1'b0, o_awaddr[`DMA_ALIGN_LOG2-1:`DMA_BYTES_LOG2]};
    assign to_page   = words_t'(page_left);

    always_comb begin
        piece = remain;
        if (to_end < piece) begin
            piece = to_end;
        end
        if (to_page < piece) begin
            piece = to_page;
        end
    end

    // held back while either length fifo is full
    assign o_awvalid  = (remain != '0) & i_wcmd_ready & i_bcmd_ready;
    assign o_awlen    = len_t'(piece - 1'b1);
    assign aw_fire    = o_awvalid & i_awready;
    assign o_cmd_len  = o_awlen;
    assign o_cmd_push = aw_fire;
    assign index_nx   = index + piece;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            index  <= '0;
            remain <= '0;
        end else if (i_update_apply) begin
            index <= '0;
        end else if (aw_fire) begin
            remain <= remain - piece;
            index  <= (index_nx == ring_size_q) ? '0 : index_nx;
        end else if (i_plan_valid && o_plan_ready) begin
            remain <= i_plan_len;
        end
    end

    always_ff @(posedge aclk) begin
        if (i_update_apply) begin
            ring_size_q <= i_ring_size;
            base_q      <= i_base_addr;
        end
    end

endmodule

/* rtl/wdata_gate.sv */
/*
 * Releases data words to W only for bursts already issued on AW and marks
 * wlast on the final beat of each one.
 */
`timescale 1ns/10ps
`include "dma_wr_params.svh"

module wdata_gate
    import dma_wr_pkg::*;
(
    input  logic  aclk,
    input  logic  aresetn,
    input  len_t  i_cmd_len,
    input  logic  i_cmd_push,
    output logic  o_cmd_ready,
    input  data_t i_data,
    input  logic  i_valid,
    output logic  o_data_ready,
    output data_t o_wdata,
    output logic  o_wvalid,
    output logic  o_wlast,
    input  logic  i_wready,
    output logic  o_busy_beats
);

    len_t cur_len;
    len_t beat;
    logic len_valid;
    logic w_fire;

    word_fifo #(
        .WIDTH      (`DMA_LEN_W),
        .DEPTH_LOG2 (`DMA_CFIFO_DEPTH_LOG2)
    ) u_len_fifo (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_data  (i_cmd_len),
        .i_valid (i_cmd_push),
        .o_ready (o_cmd_ready),
        .o_data  (cur_len),
        .o_valid (len_valid),
        .i_ready (w_fire & o_wlast),
        .o_push  ()
    );

    assign o_wdata      = i_data;
    assign o_wvalid     = len_valid & i_valid;
    assign o_wlast      = o_wvalid & (beat == cur_len);
    assign o_data_ready = len_valid & i_wready;
    assign w_fire       = o_wvalid & i_wready;
    assign o_busy_beats = len_valid;

    // beat within the open burst
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            beat <= '0;
        end else if (w_fire) begin
            beat <= o_wlast ? '0 : beat + 1'b1;
        end
    end

endmodule

/* rtl/wr_completion.sv */
/*
 * Matches each B response to the oldest issued burst and reports its length
 * one cycle later. A nonzero bresp sets o_bresp_err until reset.
 */
`timescale 1ns/10ps
`include "dma_wr_params.svh"

module wr_completion
    import dma_wr_pkg::*;
(
    input  logic       aclk,
    input  logic       aresetn,
    input  len_t       i_cmd_len,
    input  logic       i_cmd_push,
    output logic       o_cmd_ready,
    input  logic       i_bvalid,
    input  logic [1:0] i_bresp,
    output logic       o_bready,
    output len_t       o_complete_len,
    output logic       o_complete_valid,
    output logic       o_bresp_err,
    output logic       o_pending
);

    len_t head_len;
    logic len_valid;
    logic b_fire;

    word_fifo #(
        .WIDTH      (`DMA_LEN_W),
        .DEPTH_LOG2 (`DMA_CFIFO_DEPTH_LOG2)
    ) u_len_fifo (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_data  (i_cmd_len),
        .i_valid (i_cmd_push),
        .o_ready (o_cmd_ready),
        .o_data  (head_len),
        .o_valid (len_valid),
        .i_ready (b_fire),
        .o_push  ()
    );

    assign o_bready  = len_valid;
    assign b_fire    = i_bvalid & len_valid;
    assign o_pending = len_valid;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            o_complete_valid <= 1'b0;
            o_bresp_err      <= 1'b0;
        end else begin
            o_complete_valid <= b_fire;
            if (b_fire && i_bresp != 2'b00) begin
                o_bresp_err <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (b_fire) begin
            o_complete_len <= head_len;
        end
    end

endmodule

/* rtl/dma_wr_top.sv */
/*
 * AXI4 write engine that streams 32-bit words into a ring buffer in memory.
 * Base, ring size and timeout load on i_update while o_busy is low and must
 * hold for one more cycle. Update sets the free capacity to the ring size.
 */
`timescale 1ns/10ps
`include "dma_wr_params.svh"

module dma_wr_top
    import dma_wr_pkg::*;
(
    input  logic       aclk,
    input  logic       aresetn,
    // control
    input  logic       i_enable,
    output logic       o_busy,
    input  logic       i_update,
    input  addr_t      i_base_addr,
    input  words_t     i_ring_size,
    input  len_t       i_awlen,
    input  strb_t      i_wstrb,
    input  timer_t     i_timeout,
    input  len_t       i_permit_len,
    input  logic       i_permit_valid,
    output len_t       o_complete_len,
    output logic       o_complete_valid,
    // word stream
    input  data_t      i_s_data,
    input  logic       i_s_valid,
    output logic       o_s_ready,
    // AXI4 write master
    output addr_t      o_awaddr,
    output len_t       o_awlen,
    output logic [2:0] o_awsize,
    output logic [1:0] o_awburst,
    output logic [3:0] o_awcache,
    output logic       o_awvalid,
    input  logic       i_awready,
    output data_t      o_wdata,
    output strb_t      o_wstrb,
    output logic       o_wlast,
    output logic       o_wvalid,
    input  logic       i_wready,
    input  logic [1:0] i_bresp,
    input  logic       i_bvalid,
    output logic       o_bready,
    output logic       o_bresp_err
);

    data_t  fifo_data;
    logic   fifo_valid;
    logic   fifo_ready;
    logic   word_push;
    logic   update_apply;
    words_t plan_len;
    logic   plan_valid;
    logic   plan_ready;
    len_t   cmd_len;
    logic   cmd_push;
    logic   wcmd_ready;
    logic   bcmd_ready;
    logic   gate_busy;
    logic   cpl_pending;

    assign o_awsize  = AW_SIZE;
    assign o_awburst = AW_BURST;
    assign o_awcache = AW_CACHE;
    assign o_wstrb   = i_wstrb;

    // ------------------------------------------------------------------------
    // data fifo and planning
    // ------------------------------------------------------------------------
    word_fifo #(
        .WIDTH      (`DMA_DATA_W),
        .DEPTH_LOG2 (`DMA_DFIFO_DEPTH_LOG2)
    ) u_data_fifo (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_data  (i_s_data),
        .i_valid (i_s_valid),
        .o_ready (o_s_ready),
        .o_data  (fifo_data),
        .o_valid (fifo_valid),
        .i_ready (fifo_ready),
        .o_push  (word_push)
    );

    burst_planner u_planner (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .i_enable       (i_enable),
        .o_busy         (o_busy),
        .i_update       (i_update),
        .o_update_apply (update_apply),
        .i_ring_size    (i_ring_size),
        .i_awlen        (i_awlen),
        .i_timeout      (i_timeout),
        .i_word_push    (word_push),
        .i_permit_len   (i_permit_len),
        .i_permit_valid (i_permit_valid),
        .i_outstanding  (gate_busy | cpl_pending),
        .o_plan_len     (plan_len),
        .o_plan_valid   (plan_valid),
        .i_plan_ready   (plan_ready)
    );

    // ------------------------------------------------------------------------
    // AW issue and the two length branches
    // ------------------------------------------------------------------------
    burst_addr_gen u_addr_gen (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .i_update_apply (update_apply),
        .i_ring_size    (i_ring_size),
        .i_base_addr    (i_base_addr),
        .i_plan_len     (plan_len),
        .i_plan_valid   (plan_valid),
        .o_plan_ready   (plan_ready),
        .o_awaddr       (o_awaddr),
        .o_awlen        (o_awlen),
        .o_awvalid      (o_awvalid),
        .i_awready      (i_awready),
        .o_cmd_len      (cmd_len),
        .o_cmd_push     (cmd_push),
        .i_wcmd_ready   (wcmd_ready),
        .i_bcmd_ready   (bcmd_ready)
    );

    wdata_gate u_wgate (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .i_cmd_len    (cmd_len),
        .i_cmd_push   (cmd_push),
        .o_cmd_ready  (wcmd_ready),
        .i_data       (fifo_data),
        .i_valid      (fifo_valid),
        .o_data_ready (fifo_ready),
        .o_wdata      (o_wdata),
        .o_wvalid     (o_wvalid),
        .o_wlast      (o_wlast),
        .i_wready     (i_wready),
        .o_busy_beats (gate_busy)
    );

    wr_completion u_completion (
        .aclk             (aclk),
        .aresetn          (aresetn),
        .i_cmd_len        (cmd_len),
        .i_cmd_push       (cmd_push),
        .o_cmd_ready      (bcmd_ready),
        .i_bvalid         (i_bvalid),
        .i_bresp          (i_bresp),
        .o_bready         (o_bready),
        .o_complete_len   (o_complete_len),
        .o_complete_valid (o_complete_valid),
        .o_bresp_err      (o_bresp_err),
        .o_pending        (cpl_pending)
    );

endmodule

/* testbench/dma_wr_assert.sv */
/*
 * AXI write channel protocol checks for the ring write engine.
 * Checks are off while aresetn is low.
 */
`timescale 1ns/10ps

module dma_wr_assert
    import dma_wr_pkg::*;
(
    input  logic  aclk,
    input  logic  aresetn,
    input  addr_t i_awaddr,
    input  len_t  i_awlen,
    input  logic  i_awvalid,
    input  logic  i_awready,
    input  data_t i_wdata,
    input  logic  i_wlast,
    input  logic  i_wvalid,
    input  logic  i_wready
);

    int aw_open;

    // bursts accepted on AW whose wlast has not been seen yet
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            aw_open <= 0;
        end else begin
            aw_open <= aw_open + int'(i_awvalid && i_awready)
                     - int'(i_wvalid && i_wready && i_wlast);
        end
    end

    // AW must not change while it waits for awready
    aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        i_awvalid && !i_awready |=> i_awvalid && $stable(i_awaddr) && $stable(i_awlen))
        else $error("AW changed or dropped while awready was low");

    w_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        i_wvalid && !i_wready |=> i_wvalid && $stable(i_wdata) && $stable(i_wlast))
        else $error("W changed or dropped while wready was low");

    w_after_aw: assert property (@(posedge aclk) disable iff (!aresetn)
        i_wvalid |-> aw_open != 0)
        else $error("W beat without an open AW burst, wlast out of step");

endmodule

bind dma_wr_top dma_wr_assert u_assert (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .i_awaddr  (o_awaddr),
    .i_awlen   (o_awlen),
    .i_awvalid (o_awvalid),
    .i_awready (i_awready),
    .i_wdata   (o_wdata),
    .i_wlast   (o_wlast),
    .i_wvalid  (o_wvalid),
    .i_wready  (i_wready)
);

/* testbench/tb_dma_wr.sv */
/*
 * Directed tests of the ring write engine against a small AXI slave model.
 * awready and wready follow an LFSR; B answers each burst after its wlast.
 */
`timescale 1ns/10ps

module tb_dma_wr
    import dma_wr_pkg::*;
();

    localparam int TOTAL_WORDS = 133;
    localparam int WATCHDOG_NS = TOTAL_WORDS * 20 * 10;
    localparam int WAIT_LIMIT  = 2000;

    logic       aclk;
    logic       aresetn;
    logic       i_enable;
    logic       o_busy;
    logic       i_update;
    addr_t      i_base_addr;
    words_t     i_ring_size;
    len_t       i_awlen;
    strb_t      i_wstrb;
    timer_t     i_timeout;
    len_t       i_permit_len;
    logic       i_permit_valid;
    len_t       o_complete_len;
    logic       o_complete_valid;
    data_t      i_s_data;
    logic       i_s_valid;
    logic       o_s_ready;
    addr_t      o_awaddr;
    len_t       o_awlen;
    logic [2:0] o_awsize;
    logic [1:0] o_awburst;
    logic [3:0] o_awcache;
    logic       o_awvalid;
    logic       i_awready = 1'b0;
    data_t      o_wdata;
    strb_t      o_wstrb;
    logic       o_wlast;
    logic       o_wvalid;
    logic       i_wready = 1'b0;
    logic [1:0] i_bresp = 2'b00;
    logic       i_bvalid = 1'b0;
    logic       o_bready;
    logic       o_bresp_err;

    logic [15:0] lfsr = 16'd6;
    logic        bad_resp = 1'b0;
    int          b_owed;
    int          owed_nx;
    int          w_beat;
    int          w_count;
    int          checks;
    int          errors;
    len_t        aw_len_e;
    addr_t       exp_aw_addr[$];
    len_t        exp_aw_len[$];
    data_t       exp_data[$];
    len_t        wlen_q[$];
    len_t        cpl_q[$];

    dma_wr_top dut0 (.*);

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // ------------------------------------------------------------------------
    // AXI slave model, one LFSR bit per ready
    // ------------------------------------------------------------------------
    always @(posedge aclk) begin
        if (!aresetn) begin
            lfsr = 16'd6;
            b_owed    <= 0;
            i_awready <= 1'b0;
            i_wready  <= 1'b0;
            i_bvalid  <= 1'b0;
        end else begin
            i_awready <= lfsr[0];
            lfsr = lfsr_step(lfsr);
            i_wready <= lfsr[0];
            lfsr = lfsr_step(lfsr);
            owed_nx = b_owed + int'(o_wvalid && i_wready && o_wlast) - int'(i_bvalid && o_bready);
            b_owed   <= owed_nx;
            i_bvalid <= (owed_nx != 0);
            i_bresp  <= bad_resp ? 2'b10 : 2'b00;
        end
    end

    // monitors of AW, W and completions
    always @(posedge aclk) begin
        if (aresetn) begin
            if (o_awvalid && i_awready) begin
                if (exp_aw_addr.size() == 0) begin
                    errors++;
                    $display("error at %0t: AW burst that no test expected", $time);
                end else begin
                    aw_len_e = exp_aw_len.pop_front();
                    compare("o_awaddr", o_awaddr, exp_aw_addr.pop_front());
                    compare("o_awlen", o_awlen, aw_len_e);
                    // incrementing bursts of 4-byte words, bufferable
                    compare("o_awsize", o_awsize, 3'd2);
                    compare("o_awburst", o_awburst, 2'b01);
                    compare("o_awcache", o_awcache, 4'b0001);
                    wlen_q.push_back(aw_len_e);
                    cpl_q.push_back(aw_len_e);
                end
            end
            if (o_wvalid && i_wready) begin
                w_count <= w_count + 1;
                if (exp_data.size() == 0 || wlen_q.size() == 0) begin
                    errors++;
                    $display("error at %0t: W beat with no data or burst expected", $time);
                end else begin
                    compare("o_wdata", o_wdata, exp_data.pop_front());
                    compare("o_wstrb", o_wstrb, i_wstrb);
                    compare("o_wlast", o_wlast, w_beat == int'(wlen_q[0]));
                    if (w_beat == int'(wlen_q[0])) begin
                        w_beat = 0;
                        void'(wlen_q.pop_front());
                    end else begin
                        w_beat++;
                    end
                end
            end
            if (o_complete_valid) begin
                if (cpl_q.size() == 0) begin
                    errors++;
                    $display("error at %0t: completion with no burst outstanding", $time);
                end else begin
                    compare("o_complete_len", o_complete_len, cpl_q.pop_front());
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------------
    task automatic start_engine(input addr_t base, input words_t size, input len_t awlen,
                                input timer_t timeout);
        @(posedge aclk);
        i_base_addr <= base;
        i_ring_size <= size;
        i_awlen     <= awlen;
        i_timeout   <= timeout;
        i_update    <= 1'b1;
        @(posedge aclk);
        i_update <= 1'b0;
        @(posedge aclk);
        i_enable <= 1'b1;
    endtask

    task automatic stop_engine();
        int n;
        n = 0;
        @(posedge aclk);
        i_enable <= 1'b0;
        @(negedge aclk);
        while (o_busy && n < WAIT_LIMIT) begin
            @(negedge aclk);
            n++;
        end
        compare("o_busy", o_busy, 0);
    endtask

    task automatic expect_aw(input addr_t addr, input len_t len);
        exp_aw_addr.push_back(addr);
        exp_aw_len.push_back(len);
    endtask

    task automatic push_words(input int count, input data_t first);
        for (int k = 0; k < count; k++) begin
            @(posedge aclk);
            i_s_data  <= first + data_t'(k);
            i_s_valid <= 1'b1;
            exp_data.push_back(first + data_t'(k));
            @(negedge aclk);
            while (!o_s_ready) begin
                @(negedge aclk);
            end
        end
        @(posedge aclk);
        i_s_valid <= 1'b0;
    endtask

    task automatic wait_drain(input string what);
        int n;
        n = 0;
        while ((exp_aw_addr.size() != 0 || exp_data.size() != 0 || cpl_q.size() != 0)
               && n < WAIT_LIMIT) begin
            @(negedge aclk);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            errors++;
            $display("error at %0t: %s traffic did not finish in %0d cycles",
                     $time, what, WAIT_LIMIT);
        end
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------
    task automatic reset_values();
        @(negedge aclk);
        compare("o_awvalid", o_awvalid, 0);
        compare("o_wvalid", o_wvalid, 0);
        compare("o_complete_valid", o_complete_valid, 0);
        compare("o_busy", o_busy, 0);
    endtask

    task automatic full_bursts();
        start_engine(32'h0002_0000, 1024, 15, 200);
        for (int k = 0; k < 4; k++) begin
            expect_aw(32'h0002_0000 + addr_t'(64 * k), 15);
        end
        push_words(64, 32'h1000_0000);
        wait_drain("full burst");
        stop_engine();
    endtask

    task automatic timeout_burst();
        start_engine(32'h0004_0000, 1024, 15, 20);
        // partial strobes pass straight to W
        i_wstrb <= 4'b0011;
        expect_aw(32'h0004_0000, 2);
        push_words(3, 32'h2000_0000);
        wait_drain("timeout");
        stop_engine();
        @(posedge aclk);
        i_wstrb <= '1;
    endtask

    task automatic capacity_wrap();
        int w_start;
        int n;
        start_engine(32'h0000_3000, 32, 15, 200);
        expect_aw(32'h0000_3000, 15);
        expect_aw(32'h0000_3040, 15);
        // after the wrap the ring starts again at its base
        expect_aw(32'h0000_3000, 15);
        @(negedge aclk);
        w_start = w_count;
        n = 0;
        push_words(48, 32'h3000_0000);
        while (w_count - w_start < 32 && n < WAIT_LIMIT) begin
            @(negedge aclk);
            n++;
        end
        repeat (50) @(negedge aclk);
        compare("W beats before permit", w_count - w_start, 32);
        @(posedge aclk);
        i_permit_len   <= 15;
        i_permit_valid <= 1'b1;
        @(posedge aclk);
        i_permit_valid <= 1'b0;
        wait_drain("capacity");
        stop_engine();
    endtask

    task automatic page_split();
        start_engine(32'h0000_0FF0, 1024, 15, 200);
        expect_aw(32'h0000_0FF0, 3);
        expect_aw(32'h0000_1000, 11);
        push_words(16, 32'h4000_0000);
        wait_drain("page split");
        stop_engine();
    endtask

    task automatic bresp_error();
        compare("o_bresp_err", o_bresp_err, 0);
        @(posedge aclk);
        bad_resp <= 1'b1;
        start_engine(32'h0000_5000, 1024, 15, 10);
        expect_aw(32'h0000_5000, 1);
        push_words(2, 32'h5000_0000);
        wait_drain("bresp error");
        stop_engine();
        compare("o_bresp_err", o_bresp_err, 1);
        @(posedge aclk);
        bad_resp <= 1'b0;
    endtask

    initial begin
        aresetn        = 1'b0;
        i_enable       = 1'b0;
        i_update       = 1'b0;
        i_base_addr    = '0;
        i_ring_size    = '0;
        i_awlen        = '0;
        i_wstrb        = '1;
        i_timeout      = '0;
        i_permit_len   = '0;
        i_permit_valid = 1'b0;
        i_s_data       = '0;
        i_s_valid      = 1'b0;
        repeat (8) @(posedge aclk);
        aresetn <= 1'b1;
        reset_values();
        full_bursts();
        timeout_burst();
        capacity_wrap();
        page_split();
        bresp_error();
        repeat (5) @(negedge aclk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // sized from the word count of all tests
    initial begin
        #(WATCHDOG_NS);
        $display("error at %0t: watchdog expired before the tests finished", $time);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* files.f */
+incdir+rtl
rtl/dma_wr_pkg.sv
rtl/word_fifo.sv
rtl/burst_planner.sv
rtl/burst_addr_gen.sv
rtl/wdata_gate.sv
rtl/wr_completion.sv
rtl/dma_wr_top.sv
testbench/dma_wr_assert.sv
testbench/tb_dma_wr.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, pass only when the log says so
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_dma_wr \
    -f files.f -o tb_dma_wr \
    && ./obj_dir/tb_dma_wr > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "^Result: PASSED$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
